//--- sata_link.f
hw/sata_link_pkg.sv
hw/sata_prim_decode.sv
hw/sata_crc32.sv
hw/sata_link_write.sv
hw/sata_link_read.sv
hw/sata_link_layer.sv
testbench/sata_link_assertions.sv
testbench/sata_link_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the SATA link layer

TOP := sata_link_tb

.PHONY: all lint clean

all:
	verilator --binary --assert --timing -Wno-fatal --top-module $(TOP) -f sata_link.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --assert --timing --top-module $(TOP) -f sata_link.f

clean:
	rm -rf obj_dir

//--- testbench/sata_link_tb.sv
// Directed testbench for the SATA link layer acting as remote port and command layer
`timescale 1ns/1ps

module sata_link_tb;
  import sata_link_pkg::*;

  localparam int     SIZE_W       = 16;
  localparam int     CLK_PERIOD   = 20;
  localparam int     RESET_CYCLES = 8;
  localparam int     FRAME_LIMIT  = 40;
  localparam int     NUM_FRAMES   = 6;
  // Every frame loop at its limit plus the short control tests
  localparam int     WATCHDOG_CYCLES = RESET_CYCLES + NUM_FRAMES * FRAME_LIMIT + 60;
  localparam dword_t CRC_SEED     = 32'h52325032;
  localparam dword_t CRC_GEN      = 32'h04C11DB7;

  logic              clk = 1'b0;
  logic              rst;
  logic              phy_ready;
  logic              platform_ready;
  dword_t            rx_din;
  isk_t              rx_isk;
  logic              write_start;
  dword_t            write_data;
  logic [SIZE_W-1:0] write_size;
  logic              write_abort;
  dword_t            tx_dout;
  logic              tx_isk;
  logic              link_ready;
  logic              write_strobe;
  logic              write_finished;
  logic              xmit_error;
  logic              wsize_z_error;
  logic              read_start;
  logic              read_strobe;
  dword_t            read_data;
  logic              read_finished;
  logic              read_crc_ok;
  logic              remote_abort;

  integer            seed;
  int                errors = 0;
  dword_t            rd_payload[$];

  sata_link_layer #(
    .SIZE_W (SIZE_W)
  ) i_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic report_value(input string name, input dword_t got, input dword_t exp);
    errors++;
    $display("FAILED %s: got %h, expected %h", name, got, exp);
  endtask

  task automatic report_issue(input string what);
    errors++;
    $display("ERROR: %s", what);
  endtask

  // Serial CRC, one bit at a time from bit 31 down
  function automatic dword_t crc_step(input dword_t crc_in, input dword_t data);
    dword_t r;
    r = crc_in;
    for (int b = 31; b >= 0; b--) begin
      if (r[31] ^ data[b]) begin
        r = (r << 1) ^ CRC_GEN;
      end else begin
        r = r << 1;
      end
    end
    return r;
  endfunction

  task automatic drive_rx(input dword_t w, input isk_t k);
    rx_din <= w;
    rx_isk <= k;
  endtask

  task automatic settle(input int n);
    repeat (n) @(posedge clk);
    @(negedge clk);
  endtask

  task automatic test_ready();
    if (tx_dout !== PRIM_SYNC) report_value("tx_dout", tx_dout, PRIM_SYNC);
    if (tx_isk !== 1'b1) report_value("tx_isk", tx_isk, 1);
    if (link_ready !== 1'b0) report_value("link_ready", link_ready, 0);
    @(posedge clk);
    phy_ready      <= 1'b1;
    platform_ready <= 1'b1;
    settle(1);
    if (link_ready !== 1'b1) report_value("link_ready", link_ready, 1);
    @(posedge clk);
    platform_ready <= 1'b0;
    settle(1);
    if (link_ready !== 1'b0) report_value("link_ready", link_ready, 0);
    @(posedge clk);
    platform_ready <= 1'b1;
    settle(1);
    if (link_ready !== 1'b1) report_value("link_ready", link_ready, 1);
  endtask

  task automatic test_pm_deny();
    @(posedge clk);
    drive_rx(PRIM_PMREQ_P, 4'b0001);
    settle(2);
    repeat (4) begin
      if (tx_dout !== PRIM_PMNACK) report_value("tx_dout", tx_dout, PRIM_PMNACK);
      if (link_ready !== 1'b0) report_value("link_ready", link_ready, 0);
      settle(0);
      @(posedge clk);
      @(negedge clk);
    end
    @(posedge clk);
    drive_rx(PRIM_SYNC, 4'b0001);
    settle(2);
    if (tx_dout !== PRIM_SYNC) report_value("tx_dout", tx_dout, PRIM_SYNC);
    if (link_ready !== 1'b1) report_value("link_ready", link_ready, 1);
  endtask

  task automatic test_write(input int n, input bit remote_err);
    dword_t payload[$];
    dword_t exp_w[$];
    logic   exp_k[$];
    dword_t got_w[$];
    logic   got_k[$];
    dword_t crc;
    int     next_idx;
    int     strobes;
    bit     strobe_seen;
    bit     started;
    bit     seen_sof;
    bit     seen_wtrm;
    bit     finished;
    crc = CRC_SEED;
    next_idx = 0;
    strobes = 0;
    started = 1'b0;
    seen_sof = 1'b0;
    seen_wtrm = 1'b0;
    finished = 1'b0;
    exp_w.push_back(PRIM_SOF);
    exp_k.push_back(1'b1);
    for (int i = 0; i < n; i++) begin
      payload.push_back($random(seed));
      crc = crc_step(crc, payload[i]);
      exp_w.push_back(payload[i]);
      exp_k.push_back(1'b0);
    end
    exp_w.push_back(crc);
    exp_k.push_back(1'b0);
    exp_w.push_back(PRIM_EOF);
    exp_k.push_back(1'b1);
    exp_w.push_back(PRIM_WTRM);
    exp_k.push_back(1'b1);
    @(posedge clk);
    write_data  <= payload[0];
    write_size  <= SIZE_W'(n);
    write_start <= 1'b1;
    @(posedge clk);
    write_start <= 1'b0;
    for (int cyc = 0; cyc < FRAME_LIMIT && !finished; cyc++) begin
      @(negedge clk);
      strobe_seen = write_strobe;
      if (write_strobe) strobes++;
      if (write_finished) begin
        finished = 1'b1;
        if (xmit_error !== remote_err) report_value("xmit_error", xmit_error, remote_err);
      end else if (tx_isk && tx_dout === PRIM_X_RDY) begin
        started = 1'b1;
      end else if (started && !(seen_wtrm && tx_isk && tx_dout === PRIM_WTRM)) begin
        got_w.push_back(tx_dout);
        got_k.push_back(tx_isk);
        if (tx_isk && tx_dout === PRIM_SOF) seen_sof = 1'b1;
        if (tx_isk && tx_dout === PRIM_WTRM) seen_wtrm = 1'b1;
      end
      @(posedge clk);
      // Next word goes up right after each consumed one
      if (strobe_seen && next_idx + 1 < n) begin
        next_idx++;
        write_data <= payload[next_idx];
      end
      if (seen_wtrm) begin
        drive_rx(remote_err ? PRIM_R_ERR : PRIM_R_OK, 4'b0001);
      end else if (seen_sof) begin
        drive_rx(PRIM_R_IP, 4'b0001);
      end else if (started) begin
        drive_rx(PRIM_R_RDY, 4'b0001);
      end
    end
    drive_rx(PRIM_SYNC, 4'b0001);
    if (!finished) report_issue("write frame did not finish in time");
    if (strobes != n) report_value("write_strobe pulses", strobes, n);
    if (got_w.size() != exp_w.size()) begin
      report_value("transmitted frame length", got_w.size(), exp_w.size());
    end else begin
      foreach (exp_w[i]) begin
        if (got_w[i] !== exp_w[i]) report_value("tx_dout", got_w[i], exp_w[i]);
        if (got_k[i] !== exp_k[i]) report_value("tx_isk", got_k[i], exp_k[i]);
      end
    end
  endtask

  task automatic test_zero_size();
    int pulses;
    bit xrdy;
    pulses = 0;
    xrdy = 1'b0;
    @(posedge clk);
    write_size  <= '0;
    write_start <= 1'b1;
    @(posedge clk);
    write_start <= 1'b0;
    repeat (6) begin
      @(negedge clk);
      if (wsize_z_error) pulses++;
      if (tx_isk && tx_dout === PRIM_X_RDY) xrdy = 1'b1;
    end
    if (pulses != 1) report_value("wsize_z_error pulses", pulses, 1);
    if (xrdy) report_issue("X_RDY was sent for a zero-size write");
  endtask

  task automatic run_read(input bit corrupt);
    dword_t sent[$];
    dword_t q_w[$];
    logic   q_k[$];
    dword_t got[$];
    dword_t crc;
    dword_t status;
    dword_t exp_status;
    int     idx;
    int     starts;
    bit     rdy_seen;
    bit     status_seen;
    bit     finished;
    logic   crc_ok;
    crc = CRC_SEED;
    status = '0;
    idx = 0;
    starts = 0;
    rdy_seen = 1'b0;
    status_seen = 1'b0;
    finished = 1'b0;
    crc_ok = 1'b0;
    foreach (rd_payload[i]) begin
      sent.push_back(rd_payload[i]);
      crc = crc_step(crc, rd_payload[i]);
    end
    // Single bit error in the second word, CRC left as sent
    if (corrupt) sent[1] = sent[1] ^ 32'h0000_0020;
    q_w.push_back(PRIM_SOF);
    q_k.push_back(1'b1);
    foreach (sent[i]) begin
      q_w.push_back(sent[i]);
      q_k.push_back(1'b0);
    end
    q_w.push_back(crc);
    q_k.push_back(1'b0);
    q_w.push_back(PRIM_EOF);
    q_k.push_back(1'b1);
    for (int cyc = 0; cyc < FRAME_LIMIT && !finished; cyc++) begin
      @(negedge clk);
      if (read_strobe) got.push_back(read_data);
      if (read_start) starts++;
      if (read_finished) begin
        finished = 1'b1;
        crc_ok = read_crc_ok;
      end
      if (tx_isk && tx_dout === PRIM_R_RDY) rdy_seen = 1'b1;
      if (tx_isk && (tx_dout === PRIM_R_OK || tx_dout === PRIM_R_ERR)) begin
        status_seen = 1'b1;
        status = tx_dout;
      end
      @(posedge clk);
      if (status_seen) begin
        drive_rx(PRIM_SYNC, 4'b0001);
      end else if (!rdy_seen) begin
        drive_rx(PRIM_X_RDY, 4'b0001);
      end else if (idx < q_w.size()) begin
        drive_rx(q_w[idx], q_k[idx] ? 4'b0001 : 4'b0000);
        idx++;
      end else begin
        drive_rx(PRIM_WTRM, 4'b0001);
      end
    end
    drive_rx(PRIM_SYNC, 4'b0001);
    exp_status = corrupt ? PRIM_R_ERR : PRIM_R_OK;
    if (!finished) report_issue("received frame did not finish in time");
    if (status !== exp_status) report_value("tx_dout status", status, exp_status);
    if (crc_ok !== !corrupt) report_value("read_crc_ok", crc_ok, !corrupt);
    if (starts != 1) report_value("read_start pulses", starts, 1);
    if (got.size() != sent.size()) begin
      report_value("read_strobe count", got.size(), sent.size());
    end else begin
      foreach (sent[i]) begin
        if (got[i] !== sent[i]) report_value("read_data", got[i], sent[i]);
      end
    end
  endtask

  task automatic test_read_crc();
    rd_payload.delete();
    repeat (6) rd_payload.push_back($random(seed));
    run_read(1'b0);
    run_read(1'b1);
  endtask

  task automatic test_abort();
    int aborts;
    int finishes;
    int idx;
    bit rdy;
    aborts = 0;
    finishes = 0;
    idx = 0;
    rdy = 1'b0;
    for (int cyc = 0; cyc < FRAME_LIMIT && aborts == 0; cyc++) begin
      @(negedge clk);
      if (remote_abort) aborts++;
      if (read_finished) finishes++;
      if (tx_isk && tx_dout === PRIM_R_RDY) rdy = 1'b1;
      @(posedge clk);
      if (!rdy) begin
        drive_rx(PRIM_X_RDY, 4'b0001);
      end else if (idx == 0) begin
        drive_rx(PRIM_SOF, 4'b0001);
      end else if (idx <= 3) begin
        drive_rx($random(seed), 4'b0000);
      end else begin
        drive_rx(PRIM_SYNC, 4'b0001);
      end
      if (rdy) idx++;
    end
    if (aborts == 0) report_issue("remote_abort did not pulse after SYNC in mid-frame");
    repeat (3) begin
      @(negedge clk);
      if (remote_abort) aborts++;
      if (read_finished) finishes++;
    end
    if (aborts > 1) report_value("remote_abort pulses", aborts, 1);
    if (finishes != 0) report_issue("read_finished pulsed for an aborted frame");
    if (link_ready !== 1'b1) report_value("link_ready", link_ready, 1);
  endtask

  initial begin
    seed           = 84868;
    rst            = 1'b1;
    phy_ready      = 1'b0;
    platform_ready = 1'b0;
    rx_din         = PRIM_SYNC;
    rx_isk         = 4'b0001;
    write_start    = 1'b0;
    write_data     = '0;
    write_size     = '0;
    write_abort    = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    test_ready();
    test_pm_deny();
    test_write(5, 1'b0);
    test_write(4, 1'b1);
    test_zero_size();
    test_read_crc();
    test_abort();
    $display("Run complete with %0d errors", errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

//--- testbench/sata_link_assertions.sv
// Protocol checks on the link layer transmit word and its status pulses
`timescale 1ns/1ps

module sata_link_assertions (
  input logic clk,
  input logic rst,
  input logic tx_isk,
  input logic write_strobe,
  input logic write_finished,
  input logic wsize_z_error,
  input logic read_finished,
  input logic read_strobe
);

  // Data and CRC words follow a consumed payload word by one or two cycles
  a_isk_data: assert property (@(posedge clk) disable iff (rst)
    !tx_isk |-> ($past(write_strobe) || $past(write_strobe, 2)))
    else $error("tx_isk low outside a write data phase");

  a_write_status: assert property (@(posedge clk) disable iff (rst)
    !(write_finished && wsize_z_error))
    else $error("write_finished and wsize_z_error high together");

  a_read_last: assert property (@(posedge clk) disable iff (rst)
    read_finished |-> !read_strobe)
    else $error("read_strobe high with read_finished");

endmodule

bind sata_link_layer sata_link_assertions i_assertions (
  .clk            (clk),
  .rst            (rst),
  .tx_isk         (tx_isk),
  .write_strobe   (write_strobe),
  .write_finished (write_finished),
  .wsize_z_error  (wsize_z_error),
  .read_finished  (read_finished),
  .read_strobe    (read_strobe)
);

//--- hw/sata_link_layer.sv
// SATA link layer top with readiness control, PMREQ denial and transmit word selection
`timescale 1ns/1ps

module sata_link_layer #(
  parameter int SIZE_W = 16
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  phy_ready,
  input  logic                  platform_ready,
  input  sata_link_pkg::dword_t rx_din,
  input  sata_link_pkg::isk_t   rx_isk,
  input  logic                  write_start,
  input  sata_link_pkg::dword_t write_data,
  input  logic [SIZE_W-1:0]     write_size,
  input  logic                  write_abort,
  output sata_link_pkg::dword_t tx_dout,
  output logic                  tx_isk,
  output logic                  link_ready,
  output logic                  write_strobe,
  output logic                  write_finished,
  output logic                  xmit_error,
  output logic                  wsize_z_error,
  output logic                  read_start,
  output logic                  read_strobe,
  output sata_link_pkg::dword_t read_data,
  output logic                  read_finished,
  output logic                  read_crc_ok,
  output logic                  remote_abort
);
  import sata_link_pkg::*;

  link_state_t  state;
  prim_detect_t det;
  dword_t       rx_word;
  dword_t       wr_tx_dout;
  dword_t       rd_tx_dout;
  logic         wr_tx_isk;
  logic         rd_tx_isk;
  logic         write_idle;
  logic         read_idle;
  logic         engine_en;

  // Engines may only start a frame from the idle control state
  assign engine_en  = (state == IDLE);
  assign link_ready = engine_en && write_idle && read_idle;

  sata_prim_decode i_decode (
    .clk     (clk),
    .rst     (rst),
    .rx_din  (rx_din),
    .rx_isk  (rx_isk),
    .rx_word (rx_word),
    .det     (det)
  );

  sata_link_write #(
    .SIZE_W (SIZE_W)
  ) i_write (
    .clk            (clk),
    .rst            (rst),
    .en             (engine_en),
    .det            (det),
    .write_start    (write_start),
    .write_data     (write_data),
    .write_size     (write_size),
    .write_abort    (write_abort),
    .idle           (write_idle),
    .tx_dout        (wr_tx_dout),
    .tx_isk         (wr_tx_isk),
    .write_strobe   (write_strobe),
    .write_finished (write_finished),
    .xmit_error     (xmit_error),
    .wsize_z_error  (wsize_z_error)
  );

  sata_link_read i_read (
    .clk           (clk),
    .rst           (rst),
    .en            (engine_en),
    .det           (det),
    .rx_word       (rx_word),
    .idle          (read_idle),
    .tx_dout       (rd_tx_dout),
    .tx_isk        (rd_tx_isk),
    .read_start    (read_start),
    .read_strobe   (read_strobe),
    .read_data     (read_data),
    .read_finished (read_finished),
    .read_crc_ok   (read_crc_ok),
    .remote_abort  (remote_abort)
  );

  // Read side wins, then write, then the idle primitive
  always_comb begin
    if (!read_idle) begin
      tx_dout = rd_tx_dout;
      tx_isk  = rd_tx_isk;
    end else if (!write_idle) begin
      tx_dout = wr_tx_dout;
      tx_isk  = wr_tx_isk;
    end else begin
      tx_dout = (state == PM_DENY) ? PRIM_PMNACK : PRIM_SYNC;
      tx_isk  = 1'b1;
    end
  end

  // Control state machine
  always_ff @(posedge clk) begin
    if (rst) begin
      state <= NOT_READY;
    end else if (!(phy_ready && platform_ready)) begin
      state <= NOT_READY;
    end else begin
      case (state)
        NOT_READY: state <= IDLE;
        IDLE: begin
          if (det.preq) begin
            state <= PM_DENY;
          end
        end
        PM_DENY: begin
          // Keep refusing while requests continue
          if (!det.preq) begin
            state <= IDLE;
          end
        end
        default: state <= NOT_READY;
      endcase
    end
  end

endmodule

//--- hw/sata_link_read.sv
// Receive frame engine answering X_RDY, collecting the payload and replying with CRC status
`timescale 1ns/1ps

module sata_link_read (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  sata_link_pkg::prim_detect_t det,
  input  sata_link_pkg::dword_t       rx_word,
  output logic                        idle,
  output sata_link_pkg::dword_t       tx_dout,
  output logic                        tx_isk,
  output logic                        read_start,
  output logic                        read_strobe,
  output sata_link_pkg::dword_t       read_data,
  output logic                        read_finished,
  output logic                        read_crc_ok,
  output logic                        remote_abort
);
  import sata_link_pkg::*;

  read_state_t state;
  dword_t      hold;
  logic        hold_valid;
  logic        release_word;
  dword_t      crc;

  assign idle = (state == R_IDLE);

  // Receive side only ever answers with primitives
  assign tx_isk = 1'b1;

  // A new data dword pushes the held one out as payload
  assign release_word = (state == R_DATA) && det.data && hold_valid;

  sata_crc32 i_crc (
    .clk   (clk),
    .rst   (rst),
    .clear (state != R_DATA),
    .en    (release_word),
    .din   (hold),
    .crc   (crc)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= R_IDLE;
      tx_dout       <= PRIM_SYNC;
      hold_valid    <= 1'b0;
      read_start    <= 1'b0;
      read_strobe   <= 1'b0;
      read_finished <= 1'b0;
      read_crc_ok   <= 1'b0;
      remote_abort  <= 1'b0;
    end else begin
      read_start    <= 1'b0;
      read_strobe   <= release_word;
      read_finished <= 1'b0;
      remote_abort  <= 1'b0;
      case (state)
        R_IDLE: begin
          tx_dout <= PRIM_SYNC;
          if (en && det.x_rdy) begin
            tx_dout <= PRIM_R_RDY;
            state   <= R_WAIT_SOF;
          end
        end
        R_WAIT_SOF: begin
          if (det.sof) begin
            read_start <= 1'b1;
            hold_valid <= 1'b0;
            tx_dout    <= PRIM_R_IP;
            state      <= R_DATA;
          end else if (det.sync) begin
            // Remote side gave up before the frame began
            tx_dout <= PRIM_SYNC;
            state   <= R_IDLE;
          end
        end
        R_DATA: begin
          if (det.sync) begin
            remote_abort <= 1'b1;
            tx_dout      <= PRIM_SYNC;
            state        <= R_IDLE;
          end else if (det.eof) begin
            // Held word is the frame CRC
            read_crc_ok <= hold_valid && (hold == crc);
            tx_dout     <= PRIM_R_IP;
            state       <= R_CHECK;
          end else if (det.data) begin
            hold_valid <= 1'b1;
          end
        end
        R_CHECK: begin
          tx_dout <= read_crc_ok ? PRIM_R_OK : PRIM_R_ERR;
          state   <= R_STATUS;
        end
        R_STATUS: begin
          if (det.sync) begin
            read_finished <= 1'b1;
            tx_dout       <= PRIM_SYNC;
            state         <= R_IDLE;
          end
        end
        default: begin
          state <= R_IDLE;
        end
      endcase
    end
  end

  // Payload path
  always_ff @(posedge clk) begin
    if ((state == R_DATA) && det.data) begin
      hold <= rx_word;
    end
    if (release_word) begin
      read_data <= hold;
    end
  end

endmodule

//--- hw/sata_link_write.sv
// Transmit frame engine sending X_RDY, SOF, payload, CRC, EOF and WTRM up to remote status
`timescale 1ns/1ps

module sata_link_write #(
  parameter int SIZE_W = 16
) (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        en,
  input  sata_link_pkg::prim_detect_t det,
  input  logic                        write_start,
  input  sata_link_pkg::dword_t       write_data,
  input  logic [SIZE_W-1:0]           write_size,
  input  logic                        write_abort,
  output logic                        idle,
  output sata_link_pkg::dword_t       tx_dout,
  output logic                        tx_isk,
  output logic                        write_strobe,
  output logic                        write_finished,
  output logic                        xmit_error,
  output logic                        wsize_z_error
);
  import sata_link_pkg::*;

  write_state_t      state;
  logic [SIZE_W-1:0] remaining;
  logic              in_data;
  dword_t            crc;

  assign idle = (state == W_IDLE);

  // Payload words still to be taken from the command layer
  assign in_data      = (state == W_SOF) || ((state == W_DATA) && (remaining != '0));
  assign write_strobe = in_data && !write_abort;

  sata_crc32 i_crc (
    .clk   (clk),
    .rst   (rst),
    .clear (idle),
    .en    (write_strobe),
    .din   (write_data),
    .crc   (crc)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      state          <= W_IDLE;
      tx_dout        <= PRIM_SYNC;
      tx_isk         <= 1'b1;
      remaining      <= '0;
      write_finished <= 1'b0;
      xmit_error     <= 1'b0;
      wsize_z_error  <= 1'b0;
    end else begin
      write_finished <= 1'b0;
      wsize_z_error  <= 1'b0;
      case (state)
        W_IDLE: begin
          tx_dout <= PRIM_SYNC;
          tx_isk  <= 1'b1;
          if (write_start && (write_size == '0)) begin
            wsize_z_error <= 1'b1;
          end else if (write_start && en) begin
            remaining  <= write_size;
            xmit_error <= 1'b0;
            tx_dout    <= PRIM_X_RDY;
            state      <= W_XRDY;
          end
        end
        W_XRDY: begin
          if (det.r_rdy) begin
            tx_dout <= PRIM_SOF;
            state   <= W_SOF;
          end
        end
        W_SOF, W_DATA: begin
          if (write_abort) begin
            // Drop the frame and report it as failed
            tx_dout        <= PRIM_SYNC;
            tx_isk         <= 1'b1;
            write_finished <= 1'b1;
            xmit_error     <= 1'b1;
            state          <= W_IDLE;
          end else if (in_data) begin
            tx_dout   <= write_data;
            tx_isk    <= 1'b0;
            remaining <= remaining - 1'b1;
            state     <= W_DATA;
          end else begin
            // CRC is settled one cycle after the last word
            tx_dout <= crc;
            tx_isk  <= 1'b0;
            state   <= W_CRC;
          end
        end
        W_CRC: begin
          tx_dout <= PRIM_EOF;
          tx_isk  <= 1'b1;
          state   <= W_EOF;
        end
        W_EOF: begin
          tx_dout <= PRIM_WTRM;
          state   <= W_WTRM;
        end
        W_WTRM: begin
          if (det.r_ok || det.r_err) begin
            tx_dout        <= PRIM_SYNC;
            write_finished <= 1'b1;
            xmit_error     <= det.r_err;
            state          <= W_IDLE;
          end
        end
        default: begin
          state <= W_IDLE;
        end
      endcase
    end
  end

endmodule

//--- hw/sata_crc32.sv
// Running SATA CRC-32 over one dword per enabled cycle, MSB first and unreflected
`timescale 1ns/1ps

module sata_crc32 (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clear,
  input  logic                  en,
  input  sata_link_pkg::dword_t din,
  output sata_link_pkg::dword_t crc
);
  import sata_link_pkg::*;

  function automatic dword_t crc_next(input dword_t crc_in, input dword_t data);
    dword_t c;
    logic   fb;
    c = crc_in;
    for (int i = 31; i >= 0; i--) begin
      fb = c[31] ^ data[i];
      c  = {c[30:0], 1'b0};
      if (fb) begin
        c = c ^ CRC_POLY;
      end
    end
    return c;
  endfunction

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      crc <= CRC_INIT;
    end else if (en) begin
      crc <= crc_next(crc, din);
    end
  end

endmodule

//--- hw/sata_prim_decode.sv
// Receive primitive decoder that registers each incoming dword with its primitive flags
`timescale 1ns/1ps

module sata_prim_decode (
  input  logic                         clk,
  input  logic                         rst,
  input  sata_link_pkg::dword_t        rx_din,
  input  sata_link_pkg::isk_t          rx_isk,
  output sata_link_pkg::dword_t        rx_word,
  output sata_link_pkg::prim_detect_t  det
);
  import sata_link_pkg::*;

  prim_detect_t det_next;
  logic         is_prim;

  // A primitive has its K character in byte 0 only
  assign is_prim = (rx_isk == 4'b0001);

  always_comb begin
    det_next       = '0;
    det_next.sync  = is_prim && (rx_din == PRIM_SYNC);
    det_next.x_rdy = is_prim && (rx_din == PRIM_X_RDY);
    det_next.r_rdy = is_prim && (rx_din == PRIM_R_RDY);
    det_next.r_ip  = is_prim && (rx_din == PRIM_R_IP);
    det_next.r_ok  = is_prim && (rx_din == PRIM_R_OK);
    det_next.r_err = is_prim && (rx_din == PRIM_R_ERR);
    det_next.sof   = is_prim && (rx_din == PRIM_SOF);
    det_next.eof   = is_prim && (rx_din == PRIM_EOF);
    det_next.wtrm  = is_prim && (rx_din == PRIM_WTRM);
    det_next.align = is_prim && (rx_din == PRIM_ALIGN);
    // Either power-management request
    det_next.preq  = is_prim &&
                     ((rx_din == PRIM_PMREQ_S) || (rx_din == PRIM_PMREQ_P));
    det_next.data  = (rx_isk == 4'b0000);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      det <= '0;
    end else begin
      det <= det_next;
    end
  end

  // Word follows its flags by the same one cycle
  always_ff @(posedge clk) begin
    rx_word <= rx_din;
  end

endmodule

//--- hw/sata_link_pkg.sv
// SATA link layer package with dword types, primitive codes, detect flags and FSM states
package sata_link_pkg;

  // One link transfer word and its per-byte K flags
  typedef logic [31:0] dword_t;
  typedef logic [3:0]  isk_t;

  // Primitives carry K28.3 or K28.5 in byte 0
  localparam dword_t PRIM_SYNC    = 32'hB5B5957C;
  localparam dword_t PRIM_X_RDY   = 32'h5757B57C;
  localparam dword_t PRIM_R_RDY   = 32'h4A4A957C;
  localparam dword_t PRIM_R_IP    = 32'h5555B57C;
  localparam dword_t PRIM_R_OK    = 32'h3535B57C;
  localparam dword_t PRIM_R_ERR   = 32'h5656B57C;
  localparam dword_t PRIM_SOF     = 32'h3737B57C;
  localparam dword_t PRIM_EOF     = 32'hD5D5B57C;
  localparam dword_t PRIM_WTRM    = 32'h5858B57C;
  localparam dword_t PRIM_ALIGN   = 32'h7B4A4ABC;
  localparam dword_t PRIM_PMREQ_S = 32'h7575957C;
  localparam dword_t PRIM_PMREQ_P = 32'h1717B57C;
  localparam dword_t PRIM_PMNACK  = 32'hF5F5957C;

  // Frame CRC seed and generator
  localparam dword_t CRC_INIT = 32'h52325032;
  localparam dword_t CRC_POLY = 32'h04C11DB7;

  // One flag per recognised primitive, plus plain data
  typedef struct packed {
    logic sync;
    logic x_rdy;
    logic r_rdy;
    logic r_ip;
    logic r_ok;
    logic r_err;
    logic sof;
    logic eof;
    logic wtrm;
    logic align;
    logic preq;
    logic data;
  } prim_detect_t;

  typedef enum logic [1:0] {NOT_READY, IDLE, PM_DENY} link_state_t;

  typedef enum logic [2:0] {
    W_IDLE, W_XRDY, W_SOF, W_DATA, W_CRC, W_EOF, W_WTRM
  } write_state_t;

  typedef enum logic [2:0] {
    R_IDLE, R_WAIT_SOF, R_DATA, R_CHECK, R_STATUS
  } read_state_t;

endpackage
